/* project.f */
+incdir+hdl
hdl/mem_pkg.sv
hdl/cache_pkg.sv
hdl/multicycle_mem.sv
hdl/cache_array.sv
hdl/cache_ctrl.sv
hdl/cache_mem_top.sv
dv/cache_mem_tb.sv

/* Makefile */
# Verilator build and run of the cache memory testbench

VERILATOR ?= verilator
TOP       ?= cache_mem_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard hdl/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 ; cat $(LOG)
	@$(MAKE) --no-print-directory check

check:
	@grep -q '^all tests passed$$' $(LOG) && echo "PASS: $(TOP)" || { echo "FAIL: $(TOP)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/cache_mem_tb.sv */
// Self-checking testbench for the cache memory subsystem, top of the simulation built from project.f
`timescale 1ns/1ns
`default_nettype none

`include "mem_cfg.svh"

module cache_mem_tb;

   localparam int CLK_HALF     = 20;
   localparam int RESET_CYCLES = 4;
   localparam int RANDOM_OPS   = 40;
   localparam int PRELOAD_OPS  = 4 * `BLOCK_WORDS;
   // Worst case per op, a whole block fill plus handshake slack
   localparam int OP_CYCLES    = 4 * (`BLOCK_WORDS + `MEM_READ_LATENCY) + 12;
   // Random phase in set 5, table in set 4
   localparam logic [2:0] RAND_SET = 3'd5;

   logic                clk;
   logic                rst;
   logic                req_valid;
   logic                req_write;
   mem_pkg::byte_addr_t req_addr;
   mem_pkg::word_t      req_wdata;
   logic                req_ready;
   logic                rsp_valid;
   mem_pkg::word_t      rsp_rdata;

   // Last value written, one entry per word
   mem_pkg::word_t shadow [2**(`ADDR_WIDTH-1)];
   logic           rsp_expected;
   logic [15:0]    lfsr_q;
   // Four tags sharing one set, so they evict each other
   logic [8:0]     rand_tags [4];

   // Stimulus table, data is wdata for writes and expected data for reads
   bit                  tbl_write [$];
   mem_pkg::byte_addr_t tbl_addr  [$];
   mem_pkg::word_t      tbl_data  [$];
   bit                  tbl_hit   [$];
   string               tbl_label [$];

   cache_mem_top dut0 (
      .clk       (clk),
      .rst       (rst),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req_write (req_write),
      .req_addr  (req_addr),
      .req_wdata (req_wdata),
      .rsp_valid (rsp_valid),
      .rsp_rdata (rsp_rdata)
   );

   always #CLK_HALF clk = ~clk;

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input string label,
                              input logic [15:0] exp, input logic [15:0] got);
      assert (got === exp) else begin
         stop_on_error($sformatf("Error at %0t ns: %s expected 0x%h got 0x%h (%s)",
                                 $time, name, exp, got, label));
      end
   endtask

   // Galois form, taps 16 14 13 11
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 16'hB400;
      end
      return s >> 1;
   endfunction

   // One LFSR step per bit taken
   task automatic draw_bits(input int n, output logic [15:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[14:0], lfsr_q[0]};
         lfsr_q = lfsr_step(lfsr_q);
      end
   endtask

   task automatic add_row(input bit wr, input logic [15:0] addr, input logic [15:0] data,
                          input bit hit, input string label);
      tbl_write.push_back(wr);
      tbl_addr.push_back(addr);
      tbl_data.push_back(data);
      tbl_hit.push_back(hit);
      tbl_label.push_back(label);
   endtask

   // One request through the handshake, reads also wait for rsp_valid
   task automatic run_op(input bit wr, input logic [15:0] addr, input logic [15:0] wdata,
                         output logic [15:0] rdata, output int cycles);
      rdata  = '0;
      cycles = 0;
      @(posedge clk);
      req_valid <= 1'b1;
      req_write <= wr;
      req_addr  <= addr;
      req_wdata <= wdata;
      // Ready seen mid-cycle means transfer on the next edge
      do begin
         @(negedge clk);
      end while (!req_ready);
      @(posedge clk);
      req_valid <= 1'b0;
      if (!wr) begin
         rsp_expected = 1'b1;
         do begin
            @(negedge clk);
            cycles++;
         end while (!rsp_valid);
         rdata = rsp_rdata;
         @(posedge clk);
         rsp_expected = 1'b0;
      end
   endtask

   task automatic write_word(input logic [15:0] addr, input logic [15:0] data);
      logic [15:0] unused;
      int          cycles;
      run_op(1'b1, addr, data, unused, cycles);
      shadow[addr[15:1]] = data;
   endtask

   task automatic read_and_check(input logic [15:0] addr, input logic [15:0] exp,
                                 input bit want_hit, input string label);
      logic [15:0] got;
      int          cycles;
      run_op(1'b0, addr, 16'h0000, got, cycles);
      check_value("rsp_rdata", label, exp, got);
      // Hit answers on the cycle right after the transfer
      if (want_hit) begin
         check_value("rsp_valid latency", label, 16'd1, 16'(cycles));
      end
   endtask

   ////////////////////////////////////////
   // Monitors
   ////////////////////////////////////////

   // Writes and idle cycles never answer
   always @(negedge clk) begin
      if (!rst) begin
         assert (!rsp_valid || rsp_expected) else begin
            stop_on_error("rsp_valid pulsed while no read was outstanding");
         end
      end
   end

   initial begin
      int ops;
      #1;
      ops = tbl_addr.size() + PRELOAD_OPS + RANDOM_OPS;
      #((ops * OP_CYCLES + RESET_CYCLES) * 2 * CLK_HALF);
      stop_on_error("Timeout: the DUT did not finish all operations in the allowed time");
   end

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   initial begin
      logic [15:0] r_op;
      logic [15:0] r_blk;
      logic [15:0] r_off;
      logic [15:0] r_data;
      logic [15:0] addr;
      clk          = 1'b0;
      rst          = 1'b1;
      req_valid    = 1'b0;
      req_write    = 1'b0;
      req_addr     = '0;
      req_wdata    = '0;
      rsp_expected = 1'b0;
      lfsr_q       = 16'd36456;
      rand_tags    = '{9'h005, 9'h012, 9'h0a7, 9'h1c3};

      // Block A at 0x0040 and block B at 0x0440 share set 4
      add_row(1'b1, 16'h0040, 16'h1234, 1'b0, "write a0");
      add_row(1'b1, 16'h0046, 16'h5678, 1'b0, "write a3");
      add_row(1'b0, 16'h0040, 16'h1234, 1'b0, "read a0 miss");
      add_row(1'b0, 16'h0046, 16'h5678, 1'b1, "read a3 hit");
      add_row(1'b1, 16'h0046, 16'h9abc, 1'b0, "write cached a3");
      add_row(1'b0, 16'h0046, 16'h9abc, 1'b1, "read updated a3");
      add_row(1'b1, 16'h0442, 16'h0f0f, 1'b0, "write b1 uncached");
      add_row(1'b0, 16'h0442, 16'h0f0f, 1'b0, "read b1 evicts a");
      add_row(1'b0, 16'h0040, 16'h1234, 1'b0, "read a0 refill");
      add_row(1'b0, 16'h0442, 16'h0f0f, 1'b0, "read b1 refill");
      add_row(1'b0, 16'h0046, 16'h9abc, 1'b0, "read a3 refill");
      add_row(1'b0, 16'h0040, 16'h1234, 1'b1, "read a0 hit");

      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;

      // Quiet idle after reset
      repeat (3) @(negedge clk);
      check_value("req_ready", "after reset", 16'd1, 16'(req_ready));

      for (int i = 0; i < tbl_addr.size(); i++) begin
         if (tbl_write[i]) begin
            write_word(tbl_addr[i], tbl_data[i]);
         end else begin
            read_and_check(tbl_addr[i], tbl_data[i], tbl_hit[i], tbl_label[i]);
         end
      end

      // Every word of the random blocks written first
      for (int b = 0; b < 4; b++) begin
         for (int o = 0; o < `BLOCK_WORDS; o++) begin
            addr = {rand_tags[2'(b)], RAND_SET, 3'(o), 1'b0};
            write_word(addr, {addr[7:0], addr[15:8]} ^ 16'hc3a5);
         end
      end

      // Random mix, reads checked against the shadow array
      for (int i = 0; i < RANDOM_OPS; i++) begin
         draw_bits(1, r_op);
         draw_bits(2, r_blk);
         draw_bits(3, r_off);
         addr = {rand_tags[r_blk[1:0]], RAND_SET, r_off[2:0], 1'b0};
         if (r_op[0]) begin
            draw_bits(16, r_data);
            write_word(addr, r_data);
         end else begin
            read_and_check(addr, shadow[addr[15:1]], 1'b0, $sformatf("random op %0d", i));
         end
      end

      $display("all tests passed");
      $finish;
   end

endmodule

`default_nettype wire

/* hdl/cache_mem_top.sv */
// Top of the cache memory subsystem, the block the testbench instantiates as DUT
`timescale 1ns/1ns
`default_nettype none

module cache_mem_top (
   input  logic                clk,
   input  logic                rst,
   input  logic                req_valid,
   output logic                req_ready,
   input  logic                req_write,
   input  mem_pkg::byte_addr_t req_addr,
   input  mem_pkg::word_t      req_wdata,
   output logic                rsp_valid,
   output mem_pkg::word_t      rsp_rdata
);

   // Controller to array
   cache_pkg::cache_addr_u lookup_addr;
   logic                   hit;
   mem_pkg::word_t         rd_word;
   logic                   hit_write;
   mem_pkg::word_t         hit_wdata;
   logic                   fill_write;
   cache_pkg::offset_t     fill_offset;
   mem_pkg::word_t         fill_wdata;
   logic                   fill_done;

   // Controller to memory
   logic                   mem_enable;
   logic                   mem_wr;
   mem_pkg::byte_addr_t    mem_addr;
   mem_pkg::word_t         mem_wdata;
   mem_pkg::word_t         mem_rdata;
   logic                   mem_data_valid;

   cache_ctrl u_ctrl (
      .clk            (clk),
      .rst            (rst),
      .req_valid      (req_valid),
      .req_write      (req_write),
      .req_addr       (req_addr),
      .req_wdata      (req_wdata),
      .req_ready      (req_ready),
      .rsp_valid      (rsp_valid),
      .rsp_rdata      (rsp_rdata),
      .lookup_addr    (lookup_addr),
      .hit_write      (hit_write),
      .hit_wdata      (hit_wdata),
      .fill_write     (fill_write),
      .fill_offset    (fill_offset),
      .fill_wdata     (fill_wdata),
      .fill_done      (fill_done),
      .hit            (hit),
      .rd_word        (rd_word),
      .mem_enable     (mem_enable),
      .mem_wr         (mem_wr),
      .mem_addr       (mem_addr),
      .mem_wdata      (mem_wdata),
      .mem_rdata      (mem_rdata),
      .mem_data_valid (mem_data_valid)
   );

   cache_array u_array (
      .clk         (clk),
      .rst         (rst),
      .lookup_addr (lookup_addr),
      .hit         (hit),
      .rd_word     (rd_word),
      .hit_write   (hit_write),
      .hit_wdata   (hit_wdata),
      .fill_write  (fill_write),
      .fill_offset (fill_offset),
      .fill_wdata  (fill_wdata),
      .fill_done   (fill_done)
   );

   multicycle_mem u_mem (
      .clk        (clk),
      .rst        (rst),
      .enable     (mem_enable),
      .wr         (mem_wr),
      .addr       (mem_addr),
      .data_in    (mem_wdata),
      .data_out   (mem_rdata),
      .data_valid (mem_data_valid)
   );

endmodule

`default_nettype wire

/* hdl/cache_ctrl.sv */
// Cache controller instanced by the top level for handshake, hit/miss, fill and write-through
`timescale 1ns/1ns
`default_nettype none

`include "mem_cfg.svh"

module cache_ctrl (
   input  logic                    clk,
   input  logic                    rst,
   // Client
   input  logic                    req_valid,
   input  logic                    req_write,
   input  mem_pkg::byte_addr_t     req_addr,
   input  mem_pkg::word_t          req_wdata,
   output logic                    req_ready,
   output logic                    rsp_valid,
   output mem_pkg::word_t          rsp_rdata,
   // Cache array
   output cache_pkg::cache_addr_u  lookup_addr,
   output logic                    hit_write,
   output mem_pkg::word_t          hit_wdata,
   output logic                    fill_write,
   output cache_pkg::offset_t      fill_offset,
   output mem_pkg::word_t          fill_wdata,
   output logic                    fill_done,
   input  logic                    hit,
   input  mem_pkg::word_t          rd_word,
   // Backing memory
   output logic                    mem_enable,
   output logic                    mem_wr,
   output mem_pkg::byte_addr_t     mem_addr,
   output mem_pkg::word_t          mem_wdata,
   input  mem_pkg::word_t          mem_rdata,
   input  logic                    mem_data_valid
);

   localparam logic [1:0] ST_IDLE = 2'd0;
   localparam logic [1:0] ST_FILL = 2'd1;
   localparam logic [1:0] ST_RESP = 2'd2;

   // One spare bit marks all reads issued
   localparam int CNT_W = `OFFSET_WIDTH + 1;

   logic [1:0]             state;
   cache_pkg::cache_addr_u addr_q;
   cache_pkg::cache_addr_u fill_addr;
   logic [CNT_W-1:0]       issue_cnt;
   cache_pkg::offset_t     ret_cnt;
   logic                   xfer;
   logic                   issuing;
   logic                   last_ret;

   assign req_ready = (state == ST_IDLE);
   assign xfer      = req_valid && req_ready;
   assign issuing   = (state == ST_FILL) && (issue_cnt < CNT_W'(`BLOCK_WORDS));
   assign last_ret  = mem_data_valid && (ret_cnt == cache_pkg::offset_t'(`BLOCK_WORDS - 1));

   ////////////////////////////////////////
   // Address steering
   ////////////////////////////////////////

   // Fill reads walk the block of the latched request
   always_comb begin
      fill_addr.f.tag      = addr_q.f.tag;
      fill_addr.f.index    = addr_q.f.index;
      fill_addr.f.offset   = issue_cnt[`OFFSET_WIDTH-1:0];
      fill_addr.f.byte_sel = 1'b0;
   end

   // Idle looks at the live request, otherwise the latched one
   always_comb begin
      if (state == ST_IDLE) begin
         lookup_addr.addr = req_addr;
         mem_enable       = xfer && req_write;
         mem_addr         = req_addr;
      end else begin
         lookup_addr      = addr_q;
         mem_enable       = issuing;
         mem_addr         = fill_addr.addr;
      end
   end

   assign mem_wr    = (state == ST_IDLE) && req_write;
   assign mem_wdata = req_wdata;

   // Write-through also updates the cached copy when present
   assign hit_write = xfer && req_write && hit;
   assign hit_wdata = req_wdata;

   // Returning words land in order of issue
   assign fill_write  = (state == ST_FILL) && mem_data_valid;
   assign fill_offset = ret_cnt;
   assign fill_wdata  = mem_rdata;
   assign fill_done   = (state == ST_FILL) && last_ret;

   // Array holds the word by the time we answer
   assign rsp_valid = (state == ST_RESP);
   assign rsp_rdata = rd_word;

   ////////////////////////////////////////
   // FSM and counters
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (xfer) begin
         addr_q.addr <= req_addr;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= ST_IDLE;
         issue_cnt <= '0;
         ret_cnt   <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               // Writes finish in the transfer cycle
               if (xfer && !req_write) begin
                  issue_cnt <= '0;
                  ret_cnt   <= '0;
                  state     <= hit ? ST_RESP : ST_FILL;
               end
            end
            ST_FILL: begin
               if (issuing) begin
                  issue_cnt <= issue_cnt + 1'b1;
               end
               if (mem_data_valid) begin
                  ret_cnt <= ret_cnt + 1'b1;
               end
               if (last_ret) begin
                  state <= ST_RESP;
               end
            end
            ST_RESP: begin
               state <= ST_IDLE;
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // All fill reads drain before the FSM leaves the fill
   a_no_stray_data: assert property (@(posedge clk) disable iff (rst)
      (state == ST_IDLE) |-> !mem_data_valid);

endmodule

`default_nettype wire

/* hdl/cache_array.sv */
// Valid, tag and data storage of the direct-mapped cache, driven by the cache controller
`timescale 1ns/1ns
`default_nettype none

`include "mem_cfg.svh"

module cache_array (
   input  logic                    clk,
   input  logic                    rst,
   input  cache_pkg::cache_addr_u  lookup_addr,
   output logic                    hit,
   output mem_pkg::word_t          rd_word,
   input  logic                    hit_write,
   input  mem_pkg::word_t          hit_wdata,
   input  logic                    fill_write,
   input  cache_pkg::offset_t      fill_offset,
   input  mem_pkg::word_t          fill_wdata,
   input  logic                    fill_done
);

   // Per-set state
   logic [`CACHE_SETS-1:0] valid_q;
   cache_pkg::tag_t        tag_q  [`CACHE_SETS];
   mem_pkg::word_t         data_q [`CACHE_SETS][`BLOCK_WORDS];

   cache_pkg::index_t  idx;
   cache_pkg::offset_t off;

   assign idx = lookup_addr.f.index;
   assign off = lookup_addr.f.offset;

   ////////////////////////////////////////
   // Lookup
   ////////////////////////////////////////

   assign hit     = valid_q[idx] && (tag_q[idx] == lookup_addr.f.tag);
   assign rd_word = data_q[idx][off];

   ////////////////////////////////////////
   // Updates
   ////////////////////////////////////////

   // Block becomes visible only once the whole fill is in
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= '0;
      end else if (fill_done) begin
         valid_q[idx] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (fill_done) begin
         tag_q[idx] <= lookup_addr.f.tag;
      end
      // Write-through hit, word at the looked-up offset
      if (hit_write) begin
         data_q[idx][off] <= hit_wdata;
      end
      // Fill word returning from memory
      if (fill_write) begin
         data_q[idx][fill_offset] <= fill_wdata;
      end
   end

   // Controller never mixes a client write into a fill
   a_one_writer: assert property (@(posedge clk) disable iff (rst)
      !(hit_write && fill_write));

endmodule

`default_nettype wire

/* hdl/multicycle_mem.sv */
// Word memory with one-cycle write and pipelined fixed-latency read, instantiated by the top level
`timescale 1ns/1ns
`default_nettype none

`include "mem_cfg.svh"

module multicycle_mem (
   input  logic                clk,
   input  logic                rst,
   input  logic                enable,
   input  logic                wr,
   input  mem_pkg::byte_addr_t addr,
   input  mem_pkg::word_t      data_in,
   output mem_pkg::word_t      data_out,
   output logic                data_valid
);

   localparam int LAT = `MEM_READ_LATENCY;

   // Storage, one entry per 16-bit word
   mem_pkg::word_t mem_q [2**(`ADDR_WIDTH-1)];

   // Read pipeline, stage LAT-1 is the output
   mem_pkg::word_t   data_pipe [LAT];
   logic [LAT-1:0]   valid_pipe;

   mem_pkg::word_addr_t word_idx;
   mem_pkg::word_t      rd_word;
   logic                rd_fire;

   // Drop the byte bit
   assign word_idx = addr[`ADDR_WIDTH-1:1];
   assign rd_fire  = enable && !wr;
   // Zero when idle keeps the pipe quiet in waves
   assign rd_word  = rd_fire ? mem_q[word_idx] : '0;

   ////////////////////////////////////////
   // Write port
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (enable && wr) begin
         mem_q[word_idx] <= data_in;
      end
   end

   ////////////////////////////////////////
   // Read pipeline
   ////////////////////////////////////////

   // Every read moves independently, so LAT reads can be in flight
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < LAT; i++) begin
            data_pipe[i] <= '0;
         end
         valid_pipe <= '0;
      end else begin
         data_pipe[0] <= rd_word;
         for (int i = 1; i < LAT; i++) begin
            data_pipe[i] <= data_pipe[i-1];
         end
         valid_pipe <= {valid_pipe[LAT-2:0], rd_fire};
      end
   end

   assign data_out   = data_pipe[LAT-1];
   assign data_valid = valid_pipe[LAT-1];

   // Controller must only send word-aligned addresses
   a_aligned: assert property (@(posedge clk) disable iff (rst)
      enable |-> (addr[0] == 1'b0));

endmodule

`default_nettype wire

/* hdl/cache_pkg.sv */
// Types for the direct-mapped cache, address fields and the address decode union
`default_nettype none

`include "mem_cfg.svh"

package cache_pkg;

   ////////////////////////////////////////
   // Address fields
   ////////////////////////////////////////

   typedef logic [`TAG_WIDTH-1:0]    tag_t;
   typedef logic [`INDEX_WIDTH-1:0]  index_t;
   typedef logic [`OFFSET_WIDTH-1:0] offset_t;

   ////////////////////////////////////////
   // Address decode
   ////////////////////////////////////////

   // Same 16 bits, flat or split into cache fields
   typedef union packed {
      mem_pkg::byte_addr_t addr;
      struct packed {
         tag_t    tag;
         index_t  index;
         offset_t offset;
         logic    byte_sel;   // always 0 for word accesses
      } f;
   } cache_addr_u;

endpackage

`default_nettype wire

/* hdl/mem_pkg.sv */
// Types for the backing word memory, referenced by scoped name from the RTL and testbench
`default_nettype none

`include "mem_cfg.svh"

package mem_pkg;

   // One data word
   typedef logic [`WORD_WIDTH-1:0] word_t;

   // Byte address as seen by the client, bit 0 always zero
   typedef logic [`ADDR_WIDTH-1:0] byte_addr_t;

   // Index into the word array, byte bit dropped
   typedef logic [`ADDR_WIDTH-2:0] word_addr_t;

endpackage

`default_nettype wire

/* hdl/mem_cfg.svh */
// Sizing macros for the cache and backing memory, included by RTL, packages and testbench
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// Byte address and data word widths
`define ADDR_WIDTH 16
`define WORD_WIDTH 16

// Backing memory read pipeline depth, enable to data_valid
`define MEM_READ_LATENCY 4

// Direct-mapped geometry
`define CACHE_SETS 8
`define BLOCK_WORDS 8

// Address field widths, byte bit is the remaining LSB
`define INDEX_WIDTH ($clog2(`CACHE_SETS))
`define OFFSET_WIDTH ($clog2(`BLOCK_WORDS))
`define TAG_WIDTH (`ADDR_WIDTH - `INDEX_WIDTH - `OFFSET_WIDTH - 1)

`endif
